// File: Bender.yml
package:
  name: id_stage

sources:
  - dec_pkg.sv
  - arith_decoder.sv
  - xfer_decoder.sv
  - ctrl_merge.sv
  - id_ex_reg.sv
  - id_stage.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_id_stage.sv

// File: all.f
dec_pkg.sv
arith_decoder.sv
xfer_decoder.sv
ctrl_merge.sv
id_ex_reg.sv
id_stage.sv
tb_clk_gen.sv
tb_id_stage.sv

// File: arith_decoder.sv
`timescale 1ns/1ns

module arith_decoder (
    input  dec_pkg::instr_u in_instr,
    output logic            claim,
    output logic [3:0]      alu_op,
    output logic [3:0]      soh_op,
    output logic            rf_le,
    output logic            we_psr,
    output logic            jumpl
);
    import dec_pkg::*;

    logic [5:0] op3;
    logic       listed;

    assign op3   = in_instr.fmt3.op3;
    assign claim = (in_instr.fmt3.op == OP_ARITH);

    // ==============================
    // op3 lookup
    // ==============================
    always_comb begin
        alu_op = ALU_ADD;
        listed = 1'b1;
        case (op3)
            // Plain, cc, tagged and JMPL forms of add
            6'b000000, 6'b010000, 6'b100000, 6'b100010, 6'b111000: alu_op = ALU_ADD;
            6'b000100, 6'b010100, 6'b100001, 6'b100011: alu_op = ALU_SUB;
            6'b001000, 6'b011000: alu_op = ALU_ADDX;
            6'b001001, 6'b011001: alu_op = ALU_SUBX;
            6'b000001, 6'b010001: alu_op = ALU_AND;
            6'b000101, 6'b010101: alu_op = ALU_ANDN;
            6'b000010, 6'b010010: alu_op = ALU_OR;
            6'b000011, 6'b010011: alu_op = ALU_XOR;
            6'b000111, 6'b010111: alu_op = ALU_XNOR;
            6'b100101: alu_op = ALU_SLL;
            6'b100110: alu_op = ALU_SRL;
            6'b100111: alu_op = ALU_SRA;
            default:   listed = 1'b0;
        endcase
    end

    // ==============================
    // Control flags
    // ==============================
    always_comb begin
        soh_op = SOH_NONE;
        rf_le  = 1'b0;
        we_psr = 1'b0;
        jumpl  = 1'b0;
        if (claim) begin
            // Every format-3 ALU op writes rd, even unknown ones
            rf_le  = 1'b1;
            soh_op = in_instr.fmt3.i ? SOH_IMM : SOH_REG;
            // cc forms sit at 01xxxx, tagged add/sub at 1000xx
            we_psr = listed && ((op3[5:4] == 2'b01) || (op3[5:2] == 4'b1000));
            jumpl  = (op3 == 6'b111000);
        end
    end

endmodule

// File: ctrl_merge.sv
`timescale 1ns/1ns

module ctrl_merge (
    input  logic       squash,
    input  logic       arith_claim,
    input  logic [3:0] arith_alu_op,
    input  logic [3:0] arith_soh_op,
    input  logic       arith_rf_le,
    input  logic       arith_we_psr,
    input  logic       arith_jumpl,
    input  logic       xfer_claim,
    input  logic [3:0] xfer_soh_op,
    input  logic       xfer_load,
    input  logic       xfer_annul,
    input  logic       xfer_rf_le,
    input  logic       xfer_call,
    input  logic       xfer_mem_en,
    input  logic [1:0] xfer_size,
    input  logic       xfer_rw_dm,
    input  logic       xfer_branch,
    output logic [3:0] id_alu_op,
    output logic [3:0] id_soh_op,
    output logic       id_load,
    output logic       id_annul,
    output logic       id_rf_le,
    output logic       id_call,
    output logic       id_we_psr,
    output logic       id_mem_en,
    output logic [1:0] id_size,
    output logic       id_rw_dm,
    output logic       id_branch,
    output logic       id_jumpl
);

    logic arith_take;
    logic xfer_take;

    // Squash forces a bubble, arith decoder wins if both claim
    assign arith_take = arith_claim && !squash;
    assign xfer_take  = xfer_claim && !arith_claim && !squash;

    // Shared fields
    assign id_soh_op = arith_take ? arith_soh_op :
                       xfer_take  ? xfer_soh_op  : 4'd0;
    assign id_rf_le  = (arith_take && arith_rf_le) || (xfer_take && xfer_rf_le);

    // ALU side
    assign id_alu_op = arith_take ? arith_alu_op : 4'd0;
    assign id_we_psr = arith_take && arith_we_psr;
    assign id_jumpl  = arith_take && arith_jumpl;

    // Transfer side
    assign id_load   = xfer_take && xfer_load;
    assign id_annul  = xfer_take && xfer_annul;
    assign id_call   = xfer_take && xfer_call;
    assign id_mem_en = xfer_take && xfer_mem_en;
    assign id_size   = xfer_take ? xfer_size : 2'b00;
    assign id_rw_dm  = xfer_take && xfer_rw_dm;
    assign id_branch = xfer_take && xfer_branch;

endmodule

// File: dec_pkg.sv
package dec_pkg;

    // ==============================
    // Primary opcode (bits 31:30)
    // ==============================
    localparam logic [1:0] OP_FMT2  = 2'b00;
    localparam logic [1:0] OP_CALL  = 2'b01;
    localparam logic [1:0] OP_ARITH = 2'b10;
    localparam logic [1:0] OP_MEM   = 2'b11;

    // Format 2 sub-opcodes
    localparam logic [2:0] OP2_SETHI = 3'b100;
    localparam logic [2:0] OP2_BICC  = 3'b010;

    // ==============================
    // ALU operation codes
    // ==============================
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_ADDX = 4'd1;
    localparam logic [3:0] ALU_SUB  = 4'd2;
    localparam logic [3:0] ALU_SUBX = 4'd3;
    localparam logic [3:0] ALU_AND  = 4'd4;
    localparam logic [3:0] ALU_OR   = 4'd5;
    localparam logic [3:0] ALU_XOR  = 4'd6;
    localparam logic [3:0] ALU_XNOR = 4'd7;
    localparam logic [3:0] ALU_ANDN = 4'd8;
    localparam logic [3:0] ALU_SLL  = 4'd10;
    localparam logic [3:0] ALU_SRL  = 4'd11;
    localparam logic [3:0] ALU_SRA  = 4'd12;

    // Second operand handler select
    localparam logic [3:0] SOH_NONE = 4'd0;
    localparam logic [3:0] SOH_REG  = 4'd8;
    localparam logic [3:0] SOH_IMM  = 4'd9;

    // Memory access size
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // ==============================
    // Instruction word, two formats
    // ==============================
    typedef union packed {
        struct packed {
            logic [1:0]  op;
            logic        a;
            logic [3:0]  cond;
            logic [2:0]  op2;
            logic [21:0] disp22;
        } fmt2;
        struct packed {
            logic [1:0]  op;
            logic [4:0]  rd;
            logic [5:0]  op3;
            logic [4:0]  rs1;
            logic        i;
            logic [12:0] low13;
        } fmt3;
    } instr_u;

endpackage

// File: id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       out_valid,
    input  logic       out_ready,
    input  logic [3:0] id_alu_op,
    input  logic [3:0] id_soh_op,
    input  logic       id_load,
    input  logic       id_annul,
    input  logic       id_rf_le,
    input  logic       id_call,
    input  logic       id_we_psr,
    input  logic       id_mem_en,
    input  logic [1:0] id_size,
    input  logic       id_rw_dm,
    input  logic       id_branch,
    input  logic       id_jumpl,
    output logic [3:0] alu_op,
    output logic [3:0] soh_op,
    output logic       load,
    output logic       annul,
    output logic       rf_le,
    output logic       call,
    output logic       we_psr,
    output logic       mem_en,
    output logic [1:0] size,
    output logic       rw_dm,
    output logic       branch,
    output logic       jumpl
);

    logic take;

    // Accept when empty, or when the held word leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            alu_op    <= 4'd0;
            soh_op    <= 4'd0;
            load      <= 1'b0;
            annul     <= 1'b0;
            rf_le     <= 1'b0;
            call      <= 1'b0;
            we_psr    <= 1'b0;
            mem_en    <= 1'b0;
            size      <= 2'b00;
            rw_dm     <= 1'b0;
            branch    <= 1'b0;
            jumpl     <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
            alu_op    <= id_alu_op;
            soh_op    <= id_soh_op;
            load      <= id_load;
            annul     <= id_annul;
            rf_le     <= id_rf_le;
            call      <= id_call;
            we_psr    <= id_we_psr;
            mem_en    <= id_mem_en;
            size      <= id_size;
            rw_dm     <= id_rw_dm;
            branch    <= id_branch;
            jumpl     <= id_jumpl;
        end else if (out_ready) begin
            // Drained with no refill
            out_valid <= 1'b0;
        end
    end

endmodule

// File: id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  dec_pkg::instr_u in_instr,
    output logic            in_ready,
    input  logic            squash,
    output logic            out_valid,
    input  logic            out_ready,
    output logic [3:0]      alu_op,
    output logic [3:0]      soh_op,
    output logic            load,
    output logic            annul,
    output logic            rf_le,
    output logic            call,
    output logic            we_psr,
    output logic            mem_en,
    output logic [1:0]      size,
    output logic            rw_dm,
    output logic            branch,
    output logic            jumpl
);

    // Decoder outputs
    logic [3:0] arith_alu_op, arith_soh_op, xfer_soh_op;
    logic       arith_claim, arith_rf_le, arith_we_psr, arith_jumpl;
    logic       xfer_claim, xfer_load, xfer_annul, xfer_rf_le, xfer_call;
    logic       xfer_mem_en, xfer_rw_dm, xfer_branch;
    logic [1:0] xfer_size;

    // Merged word ahead of the ID/EX register
    logic [3:0] id_alu_op, id_soh_op;
    logic       id_load, id_annul, id_rf_le, id_call, id_we_psr;
    logic       id_mem_en, id_rw_dm, id_branch, id_jumpl;
    logic [1:0] id_size;

    arith_decoder i_arith_decoder (
        .in_instr (in_instr),
        .claim    (arith_claim),
        .alu_op   (arith_alu_op),
        .soh_op   (arith_soh_op),
        .rf_le    (arith_rf_le),
        .we_psr   (arith_we_psr),
        .jumpl    (arith_jumpl)
    );

    xfer_decoder i_xfer_decoder (
        .in_instr (in_instr),
        .claim    (xfer_claim),
        .soh_op   (xfer_soh_op),
        .load     (xfer_load),
        .annul    (xfer_annul),
        .rf_le    (xfer_rf_le),
        .call     (xfer_call),
        .mem_en   (xfer_mem_en),
        .size     (xfer_size),
        .rw_dm    (xfer_rw_dm),
        .branch   (xfer_branch)
    );

    // Port names line up with the wires above
    ctrl_merge i_ctrl_merge (.*);

    id_ex_reg i_id_ex_reg (.*);

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;
    import dec_pkg::*;

    localparam int DRIVE_DELAY = 5;
    localparam int TIMEOUT     = 200;

    // Each arithmetic entry holds op3, ALU code, PSR write and JMPL
    localparam logic [11:0] ARITH_TABLE [26] = '{
        {6'b000000, ALU_ADD,  1'b0, 1'b0}, {6'b010000, ALU_ADD,  1'b1, 1'b0},
        {6'b000100, ALU_SUB,  1'b0, 1'b0}, {6'b010100, ALU_SUB,  1'b1, 1'b0},
        {6'b001000, ALU_ADDX, 1'b0, 1'b0}, {6'b011000, ALU_ADDX, 1'b1, 1'b0},
        {6'b001001, ALU_SUBX, 1'b0, 1'b0}, {6'b011001, ALU_SUBX, 1'b1, 1'b0},
        {6'b100000, ALU_ADD,  1'b1, 1'b0}, {6'b100010, ALU_ADD,  1'b1, 1'b0},
        {6'b100001, ALU_SUB,  1'b1, 1'b0}, {6'b100011, ALU_SUB,  1'b1, 1'b0},
        {6'b000001, ALU_AND,  1'b0, 1'b0}, {6'b010001, ALU_AND,  1'b1, 1'b0},
        {6'b000101, ALU_ANDN, 1'b0, 1'b0}, {6'b010101, ALU_ANDN, 1'b1, 1'b0},
        {6'b000010, ALU_OR,   1'b0, 1'b0}, {6'b010010, ALU_OR,   1'b1, 1'b0},
        {6'b000011, ALU_XOR,  1'b0, 1'b0}, {6'b010011, ALU_XOR,  1'b1, 1'b0},
        {6'b000111, ALU_XNOR, 1'b0, 1'b0}, {6'b010111, ALU_XNOR, 1'b1, 1'b0},
        {6'b100101, ALU_SLL,  1'b0, 1'b0}, {6'b100110, ALU_SRL,  1'b0, 1'b0},
        {6'b100111, ALU_SRA,  1'b0, 1'b0}, {6'b111000, ALU_ADD,  1'b0, 1'b1}
    };

    // Each memory entry holds op3, load, store and size
    localparam logic [9:0] MEM_TABLE [12] = '{
        {6'b000000, 1'b1, 1'b0, SIZE_WORD}, {6'b000001, 1'b1, 1'b0, SIZE_BYTE},
        {6'b000010, 1'b1, 1'b0, SIZE_HALF}, {6'b000011, 1'b1, 1'b0, SIZE_WORD},
        {6'b001001, 1'b1, 1'b0, SIZE_BYTE}, {6'b001010, 1'b1, 1'b0, SIZE_HALF},
        {6'b001101, 1'b1, 1'b0, SIZE_BYTE}, {6'b001111, 1'b1, 1'b0, SIZE_WORD},
        {6'b000100, 1'b0, 1'b1, SIZE_WORD}, {6'b000101, 1'b0, 1'b1, SIZE_BYTE},
        {6'b000110, 1'b0, 1'b1, SIZE_HALF}, {6'b000111, 1'b0, 1'b1, SIZE_WORD}
    };

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic        squash;
    logic        out_valid;
    logic        out_ready;
    instr_u      in_instr;
    logic [3:0]  alu_op;
    logic [3:0]  soh_op;
    logic        load;
    logic        annul;
    logic        rf_le;
    logic        call;
    logic        we_psr;
    logic        mem_en;
    logic [1:0]  size;
    logic        rw_dm;
    logic        branch;
    logic        jumpl;
    logic [18:0] act_word;

    logic [18:0] exp_q[$];
    string       test_name;
    int          errors;
    int          err_start;
    int          tests_run;
    int          tests_failed;
    int          sent;
    int          received;
    bit          bp_on;
    bit          held;
    logic [18:0] held_word;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    id_stage i_dut (.*);

    assign act_word = {alu_op, soh_op, load, annul, rf_le, call, we_psr, mem_en,
                       size, rw_dm, branch, jumpl};

    // ==============================
    // Reference model
    // ==============================
    function automatic int arith_index(input logic [5:0] op3);
        for (int k = 0; k < 26; k++) begin
            if (ARITH_TABLE[k][11:6] == op3) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic int mem_index(input logic [5:0] op3);
        for (int k = 0; k < 12; k++) begin
            if (MEM_TABLE[k][9:4] == op3) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [18:0] expect_word(input instr_u w, input logic sq);
        logic [3:0] alu;
        logic [3:0] soh;
        logic [1:0] sz;
        logic       ld;
        logic       an;
        logic       wr;
        logic       cl;
        logic       psr;
        logic       men;
        logic       st;
        logic       br;
        logic       jl;
        int         k;
        alu = ALU_ADD;
        soh = SOH_NONE;
        sz  = SIZE_BYTE;
        {ld, an, wr, cl, psr, men, st, br, jl} = '0;
        if (!sq) begin
            case (w.fmt3.op)
                OP_ARITH: begin
                    wr  = 1'b1;
                    soh = w.fmt3.i ? SOH_IMM : SOH_REG;
                    k   = arith_index(w.fmt3.op3);
                    if (k >= 0) begin
                        {alu, psr, jl} = ARITH_TABLE[k][5:0];
                    end
                end
                OP_CALL: begin
                    cl = 1'b1;
                    wr = 1'b1;
                end
                OP_FMT2: begin
                    if (w.fmt2.op2 == OP2_SETHI) begin
                        wr = 1'b1;
                    end else if (w.fmt2.op2 == OP2_BICC) begin
                        br = 1'b1;
                        an = w.fmt2.a;
                    end
                end
                default: begin
                    men = 1'b1;
                    soh = w.fmt3.i ? SOH_IMM : SOH_REG;
                    k   = mem_index(w.fmt3.op3);
                    if (k >= 0) begin
                        {ld, st, sz} = MEM_TABLE[k][3:0];
                    end
                    wr = ld;
                end
            endcase
        end
        return {alu, soh, ld, an, wr, cl, psr, men, sz, st, br, jl};
    endfunction

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic instr_u make_fmt3(input logic [1:0] op, input logic [5:0] op3,
                                         input logic i);
        instr_u w;
        w = $urandom;
        w.fmt3.op  = op;
        w.fmt3.op3 = op3;
        w.fmt3.i   = i;
        return w;
    endfunction

    function automatic instr_u make_fmt2(input logic [2:0] op2, input logic [3:0] cond,
                                         input logic a);
        instr_u w;
        w = $urandom;
        w.fmt2.op   = OP_FMT2;
        w.fmt2.op2  = op2;
        w.fmt2.cond = cond;
        w.fmt2.a    = a;
        return w;
    endfunction

    function automatic logic [5:0] unlisted_op3(input bit mem);
        logic [5:0] op3;
        do begin
            op3 = $urandom;
        end while ((mem ? mem_index(op3) : arith_index(op3)) >= 0);
        return op3;
    endfunction

    // Mostly listed codes with some unknown ones
    function automatic instr_u random_instr();
        instr_u w;
        w = $urandom;
        case (w.fmt3.op)
            OP_ARITH: if ($urandom % 4 != 0) w.fmt3.op3 = ARITH_TABLE[$urandom % 26][11:6];
            OP_MEM:   if ($urandom % 4 != 0) w.fmt3.op3 = MEM_TABLE[$urandom % 12][9:4];
            OP_FMT2:  if ($urandom % 4 != 0) w.fmt2.op2 = ($urandom % 2) ? OP2_BICC : OP2_SETHI;
            default: ;
        endcase
        return w;
    endfunction

    // ==============================
    // Checking
    // ==============================
    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: %s expected %0h, actual %0h", test_name, field,
                     expected, actual);
        end
    endtask

    task automatic compare_word(input logic [18:0] exp, input logic [18:0] act);
        check_value("alu_op", exp[18:15], act[18:15]);
        check_value("soh_op", exp[14:11], act[14:11]);
        check_value("load", exp[10], act[10]);
        check_value("annul", exp[9], act[9]);
        check_value("rf_le", exp[8], act[8]);
        check_value("call", exp[7], act[7]);
        check_value("we_psr", exp[6], act[6]);
        check_value("mem_en", exp[5], act[5]);
        check_value("size", exp[4:3], act[4:3]);
        check_value("rw_dm", exp[2], act[2]);
        check_value("branch", exp[1], act[1]);
        check_value("jumpl", exp[0], act[0]);
    endtask

    // Out_ready pattern changes just after each edge
    always @(posedge clk) begin
        #DRIVE_DELAY;
        out_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
    end

    // Both handshakes seen mid-cycle where everything is stable
    always @(negedge clk) begin
        if (rst_n) begin
            // The one-entry register is full exactly when a word is outstanding
            check_value("out_valid", exp_q.size() != 0, out_valid);
            check_value("in_ready", (exp_q.size() == 0) || out_ready, in_ready);
            if (held) begin
                check_value("held out_valid", 1, out_valid);
                check_value("held word", held_word, act_word);
            end
            held      = out_valid && !out_ready;
            held_word = act_word;
            if (out_valid && out_ready) begin
                received++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output word delivered with nothing outstanding in %s",
                             test_name);
                end else begin
                    compare_word(exp_q.pop_front(), act_word);
                end
            end
            if (in_valid && in_ready) begin
                sent++;
                exp_q.push_back(expect_word(in_instr, squash));
            end
        end
    end

    // ==============================
    // Test sequencing
    // ==============================
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send(input instr_u w, input logic sq);
        int waited;
        bit accepted;
        in_valid = 1'b1;
        in_instr = w;
        squash   = sq;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            @(negedge clk);
            accepted = in_ready;
            next_cycle();
            waited++;
        end
        in_valid = 1'b0;
        squash   = 1'b0;
        if (!accepted) begin
            errors++;
            $display("Timeout in %s: in_ready stayed low for %0d cycles", test_name, TIMEOUT);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        sent      = 0;
        received  = 0;
        err_start = errors;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || out_valid) && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0 || out_valid) begin
            errors++;
            $display("Timeout in %s: words still outstanding after %0d cycles",
                     test_name, TIMEOUT);
        end
        check_value("words delivered", sent, received);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("Test %s: %s, %0d words", test_name,
                 (errors == err_start) ? "ok" : "with errors", sent);
    endtask

    initial begin
        int waited;
        void'($urandom(98225));
        in_valid     = 1'b0;
        in_instr     = '0;
        squash       = 1'b0;
        out_ready    = 1'b1;
        bp_on        = 1'b0;
        held         = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        // Reset values
        start_test("reset");
        waited = 0;
        while (!rst_n && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            errors++;
            $display("Reset was never released");
        end
        #DRIVE_DELAY;
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        check_value("control word", 0, act_word);
        check_value("in_ready", 1, in_ready);
        next_cycle();
        finish_test();

        start_test("arith");
        for (int k = 0; k < 26; k++) begin
            send(make_fmt3(OP_ARITH, ARITH_TABLE[k][11:6], 1'b0), 1'b0);
            send(make_fmt3(OP_ARITH, ARITH_TABLE[k][11:6], 1'b1), 1'b0);
        end
        repeat (16) send(make_fmt3(OP_ARITH, unlisted_op3(1'b0), $urandom), 1'b0);
        finish_test();

        start_test("xfer");
        repeat (8) send(make_fmt3(OP_CALL, $urandom, $urandom), 1'b0);
        repeat (8) send(make_fmt2(OP2_SETHI, $urandom, $urandom), 1'b0);
        for (int c = 0; c < 32; c++) begin
            send(make_fmt2(OP2_BICC, c[3:0], c[4]), 1'b0);
        end
        for (int op2 = 0; op2 < 8; op2++) begin
            if (op2 != OP2_SETHI && op2 != OP2_BICC) begin
                repeat (2) send(make_fmt2(op2, $urandom, $urandom), 1'b0);
            end
        end
        finish_test();

        start_test("memory");
        for (int k = 0; k < 12; k++) begin
            send(make_fmt3(OP_MEM, MEM_TABLE[k][9:4], 1'b0), 1'b0);
            send(make_fmt3(OP_MEM, MEM_TABLE[k][9:4], 1'b1), 1'b0);
        end
        repeat (16) send(make_fmt3(OP_MEM, unlisted_op3(1'b1), $urandom), 1'b0);
        finish_test();

        start_test("squash");
        repeat (60) send(random_instr(), $urandom);
        finish_test();

        // Random input gaps and random output stalls
        start_test("backpressure");
        bp_on = 1'b1;
        repeat (200) begin
            send(random_instr(), ($urandom % 8) == 0);
            repeat ($urandom % 3) next_cycle();
        end
        bp_on = 1'b0;
        finish_test();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: xfer_decoder.sv
`timescale 1ns/1ns

module xfer_decoder (
    input  dec_pkg::instr_u in_instr,
    output logic            claim,
    output logic [3:0]      soh_op,
    output logic            load,
    output logic            annul,
    output logic            rf_le,
    output logic            call,
    output logic            mem_en,
    output logic [1:0]      size,
    output logic            rw_dm,
    output logic            branch
);
    import dec_pkg::*;

    always_comb begin
        claim  = 1'b0;
        soh_op = SOH_NONE;
        load   = 1'b0;
        annul  = 1'b0;
        rf_le  = 1'b0;
        call   = 1'b0;
        mem_en = 1'b0;
        size   = SIZE_BYTE;
        rw_dm  = 1'b0;
        branch = 1'b0;

        case (in_instr.fmt2.op)
            // CALL writes the return address into r15
            OP_CALL: begin
                claim = 1'b1;
                call  = 1'b1;
                rf_le = 1'b1;
            end

            OP_FMT2: begin
                claim = 1'b1;
                case (in_instr.fmt2.op2)
                    OP2_SETHI: rf_le = 1'b1;
                    OP2_BICC: begin
                        branch = 1'b1;
                        annul  = in_instr.fmt2.a;
                    end
                    default: ;
                endcase
            end

            // ==============================
            // Loads and stores
            // ==============================
            OP_MEM: begin
                claim  = 1'b1;
                mem_en = 1'b1;
                soh_op = in_instr.fmt3.i ? SOH_IMM : SOH_REG;
                case (in_instr.fmt3.op3)
                    // LD, LDD, SWAP
                    6'b000000, 6'b000011, 6'b001111: begin
                        load  = 1'b1;
                        rf_le = 1'b1;
                        size  = SIZE_WORD;
                    end
                    // LDUB, LDSB, LDSTUB
                    6'b000001, 6'b001001, 6'b001101: begin
                        load  = 1'b1;
                        rf_le = 1'b1;
                        size  = SIZE_BYTE;
                    end
                    // LDUH, LDSH
                    6'b000010, 6'b001010: begin
                        load  = 1'b1;
                        rf_le = 1'b1;
                        size  = SIZE_HALF;
                    end
                    6'b000100, 6'b000111: begin
                        rw_dm = 1'b1;
                        size  = SIZE_WORD;
                    end
                    6'b000101: begin
                        rw_dm = 1'b1;
                        size  = SIZE_BYTE;
                    end
                    6'b000110: begin
                        rw_dm = 1'b1;
                        size  = SIZE_HALF;
                    end
                    default: ;
                endcase
            end

            default: ;
        endcase
    end

endmodule
